//--- source/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // data word and byte address
    typedef logic [15:0] lc3b_word;

    // register number, R0 to R7
    typedef logic [2:0] lc3b_reg;

    // only the supported subset carries a name
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // ADD/AND with bit 5 clear
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm_flag;
        logic [1:0] zero;
        lc3b_reg    sr2;
    } lc3b_inst_reg;

    // ADD/AND with bit 5 set
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm_flag;
        logic [4:0] imm5;
    } lc3b_inst_imm;

    typedef union packed {
        lc3b_inst_reg r;
        lc3b_inst_imm i;
    } lc3b_inst;

endpackage : lc3b_isa_pkg

//--- source/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } alu_op;

    // value written back to the register file
    typedef enum logic {
        wb_alu = 1'b0,
        wb_mem = 1'b1
    } wb_sel;

    // generated in decode, carried down to result
    typedef struct packed {
        alu_op      aluop;
        logic       use_imm;
        logic       load_regfile;
        logic       load_cc;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic [2:0] nzp;
        wb_sel      wbsel;
    } lc3b_control_word;

endpackage : lc3b_ctrl_pkg

//--- source/lc3b_fetch.sv
`timescale 1ns/100ps

module lc3b_fetch #(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h1000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_stall,
    input  logic                   hazard_stall,
    input  logic                   flush,
    input  lc3b_isa_pkg::lc3b_word target,
    input  logic                   resp_a,
    input  lc3b_isa_pkg::lc3b_word rdata_a,
    output logic                   read_a,
    output lc3b_isa_pkg::lc3b_word address_a,
    output logic                   if_valid,
    output lc3b_isa_pkg::lc3b_word if_inst,
    output lc3b_isa_pkg::lc3b_word if_pc
);

    // next fetch address, may run ahead of address_a after a flush
    lc3b_isa_pkg::lc3b_word pc;
    lc3b_isa_pkg::lc3b_word pc_next;
    logic drop;
    logic take;
    logic if_valid_next;

    // a word fetched before a flush is thrown away
    assign take = resp_a && !drop && !flush;

    always_comb begin
        pc_next = pc;
        if (flush) begin
            pc_next = target;
        end else if (take) begin
            pc_next = address_a + 16'd2;
        end
    end

    always_comb begin
        if_valid_next = if_valid;
        if (flush) begin
            if_valid_next = 1'b0;
        end else if (take) begin
            if_valid_next = 1'b1;
        end else if (!mem_stall && !hazard_stall) begin
            if_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            address_a <= RESET_PC;
            read_a    <= 1'b0;
            drop      <= 1'b0;
            if_valid  <= 1'b0;
        end else begin
            pc       <= pc_next;
            drop     <= read_a && !resp_a && (drop || flush);
            if_valid <= if_valid_next;
            // start a read only once the slot is sure to be free at resp_a
            if (!read_a || resp_a) begin
                read_a    <= !if_valid_next;
                address_a <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if_inst <= rdata_a;
            if_pc   <= address_a + 16'd2;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        read_a && !resp_a |=> $stable(address_a));

endmodule : lc3b_fetch

//--- source/lc3b_decode.sv
`timescale 1ns/100ps

module lc3b_decode (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_stall,
    input  logic                            flush,
    input  logic                            if_valid,
    input  lc3b_isa_pkg::lc3b_word          if_inst,
    input  lc3b_isa_pkg::lc3b_word          if_pc,
    input  lc3b_isa_pkg::lc3b_reg           ex_dest,
    input  logic                            ex_loads,
    input  lc3b_isa_pkg::lc3b_reg           wb_dest,
    input  logic                            wb_loads,
    input  lc3b_isa_pkg::lc3b_word          wb_data,
    output logic                            hazard_stall,
    output logic                            id_valid,
    output lc3b_ctrl_pkg::lc3b_control_word id_ctrl,
    output lc3b_isa_pkg::lc3b_word          id_src1_data,
    output lc3b_isa_pkg::lc3b_word          id_src2_data,
    output lc3b_isa_pkg::lc3b_word          id_imm,
    output lc3b_isa_pkg::lc3b_word          id_pc,
    output lc3b_isa_pkg::lc3b_reg           id_dest
);

    lc3b_isa_pkg::lc3b_inst          inst;
    lc3b_ctrl_pkg::lc3b_control_word ctrl;
    lc3b_isa_pkg::lc3b_word          imm;
    lc3b_isa_pkg::lc3b_reg           src2;
    lc3b_isa_pkg::lc3b_word          regs [8];
    logic use_src1;
    logic use_src2;
    logic id_loads;
    logic src1_busy;
    logic src2_busy;

    assign inst = if_inst;

    always_comb begin
        ctrl     = '0;
        imm      = 16'h0000;
        use_src1 = 1'b0;
        use_src2 = 1'b0;
        src2     = inst.r.sr2;
        case (inst.r.opcode)
            lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
                ctrl.aluop = (inst.r.opcode == lc3b_isa_pkg::op_add) ?
                             lc3b_ctrl_pkg::alu_add : lc3b_ctrl_pkg::alu_and;
                // bit 5 picks which view of the word applies
                ctrl.use_imm      = inst.i.imm_flag;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                use_src1          = 1'b1;
                use_src2          = !inst.r.imm_flag;
                imm               = {{11{inst.i.imm5[4]}}, inst.i.imm5};
            end
            lc3b_isa_pkg::op_not: begin
                ctrl.aluop        = lc3b_ctrl_pkg::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                use_src1          = 1'b1;
            end
            lc3b_isa_pkg::op_ldr: begin
                ctrl.use_imm      = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.wbsel        = lc3b_ctrl_pkg::wb_mem;
                use_src1          = 1'b1;
                imm               = {{10{if_inst[5]}}, if_inst[5:0]};
            end
            lc3b_isa_pkg::op_str: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                use_src1       = 1'b1;
                use_src2       = 1'b1;
                // store data comes from the SR field
                src2           = inst.r.dr;
                imm            = {{10{if_inst[5]}}, if_inst[5:0]};
            end
            lc3b_isa_pkg::op_br: begin
                ctrl.aluop     = lc3b_ctrl_pkg::alu_pass;
                ctrl.is_branch = 1'b1;
                ctrl.nzp       = if_inst[11:9];
                imm            = {{7{if_inst[8]}}, if_inst[8:0]};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // producers in execute (own register) and in result
    assign id_loads  = id_valid && id_ctrl.load_regfile;
    assign src1_busy = (id_loads && id_dest == inst.r.sr1) ||
                       (ex_loads && ex_dest == inst.r.sr1);
    assign src2_busy = (id_loads && id_dest == src2) || (ex_loads && ex_dest == src2);
    assign hazard_stall = if_valid && ((use_src1 && src1_busy) || (use_src2 && src2_busy));

    always_ff @(posedge clk) begin
        if (wb_loads) begin
            regs[wb_dest] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (!mem_stall) begin
            id_valid <= if_valid && !hazard_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            id_ctrl      <= ctrl;
            id_src1_data <= regs[inst.r.sr1];
            id_src2_data <= regs[src2];
            id_imm       <= imm;
            id_pc        <= if_pc;
            id_dest      <= inst.r.dr;
        end
    end

    // a held instruction is still waiting in the next cycle
    a_hazard_holds_inst: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_stall && !flush |=> if_valid && $stable(if_inst));

endmodule : lc3b_decode

//--- source/lc3b_execute.sv
`timescale 1ns/100ps

module lc3b_execute (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_stall,
    input  logic                            flush,
    input  logic                            id_valid,
    input  lc3b_ctrl_pkg::lc3b_control_word id_ctrl,
    input  lc3b_isa_pkg::lc3b_word          id_src1_data,
    input  lc3b_isa_pkg::lc3b_word          id_src2_data,
    input  lc3b_isa_pkg::lc3b_word          id_imm,
    input  lc3b_isa_pkg::lc3b_word          id_pc,
    input  lc3b_isa_pkg::lc3b_reg           id_dest,
    output logic                            ex_valid,
    output lc3b_ctrl_pkg::lc3b_control_word ex_ctrl,
    output lc3b_isa_pkg::lc3b_word          ex_alu,
    output lc3b_isa_pkg::lc3b_word          ex_target,
    output lc3b_isa_pkg::lc3b_word          ex_store_data,
    output lc3b_isa_pkg::lc3b_reg           ex_dest,
    output logic                            ex_loads
);

    lc3b_isa_pkg::lc3b_word scaled;
    lc3b_isa_pkg::lc3b_word opb;
    lc3b_isa_pkg::lc3b_word alu_out;

    // word offsets, for LDR/STR and BR alike
    assign scaled = {id_imm[14:0], 1'b0};

    always_comb begin
        if (!id_ctrl.use_imm) begin
            opb = id_src2_data;
        end else if (id_ctrl.mem_read || id_ctrl.mem_write) begin
            opb = scaled;
        end else begin
            opb = id_imm;
        end
    end

    always_comb begin
        unique case (id_ctrl.aluop)
            lc3b_ctrl_pkg::alu_add:  alu_out = id_src1_data + opb;
            lc3b_ctrl_pkg::alu_and:  alu_out = id_src1_data & opb;
            lc3b_ctrl_pkg::alu_not:  alu_out = ~id_src1_data;
            lc3b_ctrl_pkg::alu_pass: alu_out = id_src1_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!mem_stall) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            ex_ctrl       <= id_ctrl;
            ex_alu        <= alu_out;
            // id_pc is already the incremented PC
            ex_target     <= id_pc + scaled;
            ex_store_data <= id_src2_data;
            ex_dest       <= id_dest;
        end
    end

    assign ex_loads = ex_valid && ex_ctrl.load_regfile;

endmodule : lc3b_execute

//--- source/lc3b_result.sv
`timescale 1ns/100ps

module lc3b_result (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ex_valid,
    input  lc3b_ctrl_pkg::lc3b_control_word ex_ctrl,
    input  lc3b_isa_pkg::lc3b_word          ex_alu,
    input  lc3b_isa_pkg::lc3b_word          ex_target,
    input  lc3b_isa_pkg::lc3b_word          ex_store_data,
    input  lc3b_isa_pkg::lc3b_reg           ex_dest,
    input  logic                            resp_b,
    input  lc3b_isa_pkg::lc3b_word          rdata_b,
    output logic                            read_b,
    output logic                            write_b,
    output lc3b_isa_pkg::lc3b_word          address_b,
    output lc3b_isa_pkg::lc3b_word          wdata_b,
    output logic                            mem_stall,
    output logic                            flush,
    output lc3b_isa_pkg::lc3b_word          target,
    output lc3b_isa_pkg::lc3b_reg           wb_dest,
    output logic                            wb_loads,
    output lc3b_isa_pkg::lc3b_word          wb_data
);

    logic [2:0] cc;
    logic complete;

    // request held from the stage register until resp_b
    assign read_b    = ex_valid && ex_ctrl.mem_read;
    assign write_b   = ex_valid && ex_ctrl.mem_write;
    assign address_b = ex_alu;
    assign wdata_b   = ex_store_data;

    assign mem_stall = (read_b || write_b) && !resp_b;
    assign complete  = ex_valid && !mem_stall;

    assign wb_data  = (ex_ctrl.wbsel == lc3b_ctrl_pkg::wb_mem) ? rdata_b : ex_alu;
    assign wb_dest  = ex_dest;
    assign wb_loads = complete && ex_ctrl.load_regfile;

    // nzp = 000 never matches, which makes the NOP
    assign flush  = complete && ex_ctrl.is_branch && |(ex_ctrl.nzp & cc);
    assign target = ex_target;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc <= 3'b010;
        end else if (complete && ex_ctrl.load_cc) begin
            if (wb_data[15]) begin
                cc <= 3'b100;
            end else if (wb_data == 16'h0000) begin
                cc <= 3'b010;
            end else begin
                cc <= 3'b001;
            end
        end
    end

    a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_b && write_b));

endmodule : lc3b_result

//--- source/cpu_datapath.sv
`timescale 1ns/100ps

module cpu_datapath #(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h1000
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // port A, instruction reads
    input  logic                   resp_a,
    input  lc3b_isa_pkg::lc3b_word rdata_a,
    output logic                   read_a,
    output lc3b_isa_pkg::lc3b_word address_a,

    // port B, data words
    input  logic                   resp_b,
    input  lc3b_isa_pkg::lc3b_word rdata_b,
    output logic                   read_b,
    output logic                   write_b,
    output lc3b_isa_pkg::lc3b_word address_b,
    output lc3b_isa_pkg::lc3b_word wdata_b
);

    // pipeline control
    logic mem_stall;
    logic hazard_stall;
    logic flush;
    lc3b_isa_pkg::lc3b_word target;

    // fetch to decode
    logic if_valid;
    lc3b_isa_pkg::lc3b_word if_inst;
    lc3b_isa_pkg::lc3b_word if_pc;

    // decode to execute
    logic id_valid;
    lc3b_ctrl_pkg::lc3b_control_word id_ctrl;
    lc3b_isa_pkg::lc3b_word id_src1_data;
    lc3b_isa_pkg::lc3b_word id_src2_data;
    lc3b_isa_pkg::lc3b_word id_imm;
    lc3b_isa_pkg::lc3b_word id_pc;
    lc3b_isa_pkg::lc3b_reg id_dest;

    // execute to result
    logic ex_valid;
    lc3b_ctrl_pkg::lc3b_control_word ex_ctrl;
    lc3b_isa_pkg::lc3b_word ex_alu;
    lc3b_isa_pkg::lc3b_word ex_target;
    lc3b_isa_pkg::lc3b_word ex_store_data;
    lc3b_isa_pkg::lc3b_reg ex_dest;
    logic ex_loads;

    // writeback into the register file
    lc3b_isa_pkg::lc3b_reg wb_dest;
    logic wb_loads;
    lc3b_isa_pkg::lc3b_word wb_data;

    lc3b_fetch #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk, .rst_n, .mem_stall, .hazard_stall, .flush, .target,
        .resp_a, .rdata_a, .read_a, .address_a,
        .if_valid, .if_inst, .if_pc
    );

    lc3b_decode decode_i (
        .clk, .rst_n, .mem_stall, .flush,
        .if_valid, .if_inst, .if_pc,
        .ex_dest, .ex_loads, .wb_dest, .wb_loads, .wb_data,
        .hazard_stall, .id_valid, .id_ctrl,
        .id_src1_data, .id_src2_data, .id_imm, .id_pc, .id_dest
    );

    lc3b_execute execute_i (
        .clk, .rst_n, .mem_stall, .flush,
        .id_valid, .id_ctrl, .id_src1_data, .id_src2_data, .id_imm, .id_pc, .id_dest,
        .ex_valid, .ex_ctrl, .ex_alu, .ex_target, .ex_store_data, .ex_dest, .ex_loads
    );

    lc3b_result result_i (
        .clk, .rst_n,
        .ex_valid, .ex_ctrl, .ex_alu, .ex_target, .ex_store_data, .ex_dest,
        .resp_b, .rdata_b, .read_b, .write_b, .address_b, .wdata_b,
        .mem_stall, .flush, .target, .wb_dest, .wb_loads, .wb_data
    );

endmodule : cpu_datapath

//--- tb/cpu_datapath_checker.sv
`timescale 1ns/100ps

module cpu_datapath_checker #(
    parameter logic [15:0] RESET_PC = 16'h1000
) (
    input logic        clk,
    input logic        rst_n,
    input logic        read_a,
    input logic [15:0] address_a,
    input logic        read_b,
    input logic        write_b,
    input logic        resp_b,
    input logic [15:0] address_b,
    input logic [15:0] wdata_b
);

    // expected stores in program order
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    string test_name = "none";
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int total_errors = 0;
    int reset_cycles = 0;
    logic first_fetch = 1'b0;

    function automatic logic [2:0] cc_of(input logic [15:0] v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == 16'h0000) ? 3'b010 : 3'b001;
    endfunction

    function automatic int remaining();
        return exp_addr.size();
    endfunction

    task automatic fail_value(input string what, input logic [15:0] exp, input logic [15:0] act);
        $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, act);
        test_errors++;
    endtask

    task automatic fail_plain(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic report_timeout();
        fail_plain("timeout while waiting for the program's stores");
    endtask

    task automatic end_test();
        if (exp_addr.size() > 0) begin
            fail_plain($sformatf("%0d expected stores never happened", exp_addr.size()));
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    // instruction-set model stepping one instruction at a time
    task automatic run_model(input logic [15:0] prog [128], input logic [15:0] data [64]);
        logic [15:0] r [8];
        logic [15:0] mem [64];
        logic [15:0] pc;
        logic [15:0] npc;
        logic [15:0] inst;
        logic [15:0] opb;
        logic [15:0] addr;
        logic [15:0] res;
        logic [2:0] cc;
        int steps;
        logic done;
        r = '{default: 16'h0000};
        mem = data;
        pc = RESET_PC;
        cc = 3'b010;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4000) begin
            inst = prog[7'((pc - RESET_PC) >> 1)];
            npc = pc + 16'd2;
            opb = inst[5] ? {{11{inst[4]}}, inst[4:0]} : r[inst[2:0]];
            addr = r[inst[8:6]] + {{9{inst[5]}}, inst[5:0], 1'b0};
            case (inst[15:12])
                4'b0001, 4'b0101, 4'b1001, 4'b0110: begin
                    if (inst[15:12] == 4'b0001) begin
                        res = r[inst[8:6]] + opb;
                    end else if (inst[15:12] == 4'b0101) begin
                        res = r[inst[8:6]] & opb;
                    end else if (inst[15:12] == 4'b1001) begin
                        res = ~r[inst[8:6]];
                    end else begin
                        res = mem[addr[6:1]];
                    end
                    r[inst[11:9]] = res;
                    cc = cc_of(res);
                end
                4'b0111: begin
                    mem[addr[6:1]] = r[inst[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[inst[11:9]]);
                end
                default: begin
                    if ((inst[11:9] & cc) != 3'b000) begin
                        npc = npc + {{6{inst[8]}}, inst[8:0], 1'b0};
                        // a branch to itself ends the program
                        done = (npc == pc);
                    end
                end
            endcase
            pc = npc;
            steps++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_cycles >= 2 && (read_a === 1'b1 || read_b === 1'b1 || write_b === 1'b1)) begin
                fail_plain("a memory request was active during reset");
            end
            reset_cycles++;
            first_fetch = 1'b1;
        end else begin
            reset_cycles = 0;
            if (first_fetch && read_a) begin
                first_fetch = 1'b0;
                if (address_a !== RESET_PC) begin
                    fail_value("first fetch address", RESET_PC, address_a);
                end
            end
            if (write_b && resp_b) begin
                if (exp_addr.size() == 0) begin
                    fail_plain("a store happened that the model does not expect");
                end else begin
                    if (address_b !== exp_addr[0]) begin
                        fail_value("store address", exp_addr[0], address_b);
                    end
                    if (wdata_b !== exp_data[0]) begin
                        fail_value("store data", exp_data[0], wdata_b);
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                end
            end
        end
    end

endmodule : cpu_datapath_checker

//--- tb/tb_cpu_datapath.sv
`timescale 1ns/100ps

module tb_cpu_datapath;

    localparam logic [15:0] RESET_PC = 16'h1000;

    logic clk;
    logic rst_n;
    logic resp_a;
    logic resp_b;
    logic read_a;
    logic read_b;
    logic write_b;
    logic [15:0] rdata_a;
    logic [15:0] address_a;
    logic [15:0] rdata_b;
    logic [15:0] address_b;
    logic [15:0] wdata_b;
    logic [15:0] imem [128];
    logic [15:0] dmem [64];
    integer seed;
    int lat_a;
    int wait_a;
    int lat_b;
    int wait_b;
    int n_prog;
    logic [2:0] last_dest;

    cpu_datapath #(
        .RESET_PC(RESET_PC)
    ) cpu_datapath_i (
        .clk, .rst_n, .resp_a, .rdata_a, .read_a, .address_a,
        .resp_b, .rdata_b, .read_b, .write_b, .address_b, .wdata_b
    );

    cpu_datapath_checker #(
        .RESET_PC(RESET_PC)
    ) checker_i (
        .clk, .rst_n, .read_a, .address_a,
        .read_b, .write_b, .resp_b, .address_b, .wdata_b
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        logic [15:0] idx;
        idx = (addr - RESET_PC) >> 1;
        return (addr >= RESET_PC && idx < 128) ? imem[idx[6:0]] : 16'h0000;
    endfunction

    // instruction memory answering after 1 to 3 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            resp_a <= 1'b0;
            wait_a <= 0;
        end else begin
            resp_a <= 1'b0;
            if (read_a && !resp_a) begin
                if (wait_a >= lat_a) begin
                    resp_a  <= 1'b1;
                    rdata_a <= fetch_word(address_a);
                    wait_a  <= 0;
                    lat_a   <= rand_below(3);
                end else begin
                    wait_a <= wait_a + 1;
                end
            end
        end
    end

    // data memory with whole-word access
    always @(posedge clk) begin
        if (!rst_n) begin
            resp_b <= 1'b0;
            wait_b <= 0;
        end else begin
            resp_b <= 1'b0;
            if ((read_b || write_b) && !resp_b) begin
                if (wait_b >= lat_b) begin
                    resp_b  <= 1'b1;
                    rdata_b <= dmem[address_b[6:1]];
                    if (write_b) begin
                        dmem[address_b[6:1]] <= wdata_b;
                    end
                    wait_b <= 0;
                    lat_b  <= rand_below(3);
                end else begin
                    wait_b <= wait_b + 1;
                end
            end
        end
    end

    task automatic emit(input logic [15:0] w);
        imem[n_prog] = w;
        n_prog++;
    endtask

    // any register but the data base R6
    function automatic logic [2:0] pick_dest();
        logic [2:0] d;
        d = 3'(rand_below(7));
        return (d == 3'd6) ? 3'd7 : d;
    endfunction

    task automatic emit_random(input int kind);
        logic [2:0] d;
        logic [2:0] s1;
        logic [2:0] s2;
        logic [3:0] op;
        int pick;
        d = pick_dest();
        s1 = (kind == 4) ? last_dest : 3'(rand_below(8));
        s2 = 3'(rand_below(8));
        pick = rand_below(kind == 1 ? 3 : (kind == 3 ? 6 : 5));
        if (pick <= 1) begin
            op = (pick == 0) ? 4'b0001 : 4'b0101;
            if (rand_below(2) == 1) begin
                emit({op, d, s1, 1'b1, 5'(rand_below(32))});
            end else begin
                emit({op, d, s1, 3'b000, s2});
            end
            last_dest = d;
        end else if (pick == 2) begin
            emit({4'b1001, d, s1, 6'h3F});
            last_dest = d;
        end else if (pick == 3) begin
            emit({4'b0110, d, 3'd6, 6'(rand_below(24))});
            last_dest = d;
        end else if (pick == 4) begin
            emit({4'b0111, s1, 3'd6, 6'(rand_below(24))});
        end else begin
            emit({4'b0000, 3'(rand_below(8)), 9'(rand_below(3) + 1)});
        end
    endtask

    task automatic generate_program(input int kind);
        n_prog = 0;
        for (int i = 0; i < 128; i++) begin
            imem[i] = 16'h0000;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 16'($random(seed));
        end
        for (int r = 0; r < 8; r++) begin
            emit({4'b0101, 3'(r), 3'(r), 1'b1, 5'd0});
        end
        for (int r = 0; r < 8; r++) begin
            if (r != 6) begin
                emit({4'b0001, 3'(r), 3'(r), 1'b1, 5'(rand_below(32))});
            end
        end
        if (kind > 0) begin
            for (int i = 0; i < 30; i++) begin
                emit_random(kind);
            end
        end
        for (int r = 0; r < 8; r++) begin
            emit({4'b0111, 3'(r), 3'd6, 6'(24 + r)});
        end
        emit({4'b0000, 3'b111, 9'h1FF});
    endtask

    task automatic run_test(input string name, input int kind);
        int cycles;
        @(posedge clk);
        rst_n <= 1'b0;
        checker_i.begin_test(name);
        generate_program(kind);
        checker_i.run_model(imem, dmem);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (checker_i.remaining() > 0 && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (checker_i.remaining() > 0) begin
            checker_i.report_timeout();
        end
        // a stray store would show up in this window
        cycles = 0;
        while (cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        checker_i.end_test();
    endtask

    initial begin
        seed = 32'h7633_c324;
        rst_n = 1'b0;
        resp_a = 1'b0;
        resp_b = 1'b0;
        rdata_a = 16'h0000;
        rdata_b = 16'h0000;
        lat_a = 0;
        lat_b = 0;
        wait_a = 0;
        wait_b = 0;
        last_dest = 3'd0;
        run_test("reset", 0);
        run_test("alu_ops", 1);
        run_test("load_store", 2);
        run_test("branches", 3);
        run_test("hazards_latency", 4);
        $display("tests run %0d, failed %0d, errors %0d",
                 checker_i.tests_run, checker_i.tests_failed, checker_i.total_errors);
        if (checker_i.total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_cpu_datapath

//--- verilog.f
source/lc3b_isa_pkg.sv
source/lc3b_ctrl_pkg.sv
source/lc3b_fetch.sv
source/lc3b_decode.sv
source/lc3b_execute.sv
source/lc3b_result.sv
source/cpu_datapath.sv
tb/cpu_datapath_checker.sv
tb/tb_cpu_datapath.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_datapath
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
